/* sim.f */
rtl/ring_pkg.sv
rtl/ring_nic.sv
rtl/ring_node.sv
rtl/ring_soc.sv
dv/ring_soc_checker.sv
dv/ring_soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ring_soc testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir

# compile everything in sim.f with the testbench on top
verilator --binary --timing --assert \
	--top-module ring_soc_tb \
	--Mdir "$MDIR" \
	-f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# keep running past assertion hits so the closing summary is printed
"./$MDIR/Vring_soc_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints the fail line on any error or timeout
if grep -q "Simulation failed" "$LOG"; then
	echo "failure reported in $LOG"
	exit 1
fi

exit 0

/* dv/ring_soc_tb.sv */
module ring_soc_tb;
	import ring_pkg::*;

	// ------------------------------
	// run parameters
	// ------------------------------

	localparam int CLK_HALF = 20;
	// inputs change this long after a rising edge
	localparam int DRIVE_DLY = 5;
	localparam int RESET_CYCLES = 5;
	localparam int SEED = 26;
	localparam int RAND_CMDS = 200;
	// reset, zero reads, write and read back, burst, raw, unowned, random, drain
	localparam int STIM_CYCLES = RESET_CYCLES + NUM_NODES * NUM_REGS + NUM_NODES * 8
		+ 8 + NUM_NODES * 2 + 8 + RAND_CMDS + RING_LATENCY + 2;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2 + 20;
	localparam node_id_t LAST_ID = node_id_t'(NUM_NODES);

	logic clk100 = 1'b0;
	logic reset_i;
	host_cmd_t cmd;
	host_rsp_t rsp;

	int cycle_cnt;
	// responses owed by the DUT and responses seen
	int exp_rsp_cnt;
	int got_rsp_cnt;
	int drain_errs;
	int assert_errs;
	int unsigned rnd;
	node_id_t rnd_id;

	ring_soc u_dut (
		.clk100 (clk100),
		.reset_i(reset_i),
		.cmd_i  (cmd),
		.rsp_o  (rsp)
	);

	always begin
		#CLK_HALF clk100 = ~clk100;
	end

	// ------------------------------
	// timeout and response count
	// ------------------------------

	always @(posedge clk100) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, only %0d of %0d responses came back",
				cycle_cnt, got_rsp_cnt, exp_rsp_cnt);
			$display("Simulation failed");
			$finish;
		end
	end

	always @(posedge clk100) begin
		if (!reset_i && rsp.valid) begin
			got_rsp_cnt <= got_rsp_cnt + 1;
		end
	end

	// ------------------------------
	// helpers
	// ------------------------------

	function automatic logic is_owned(input node_id_t id);
		return (id != NIC_ID) && (id <= LAST_ID);
	endfunction

	// data word built from node id and register index
	function automatic word_t fill_word(input node_id_t id, input reg_idx_t idx);
		return {4'hc, 1'b0, id, 4'h0, idx, 8'h5a, 1'b0, id, idx};
	endfunction

	// one command strobe, held for exactly one clock
	task automatic send_cmd(input logic we, input node_id_t id, input reg_idx_t idx,
		input word_t dat);
		@(posedge clk100);
		#DRIVE_DLY;
		cmd.valid = 1'b1;
		cmd.we = we;
		cmd.adr = {id, idx};
		cmd.dat = dat;
		// reads and bounces come back, owned writes do not
		if (!we || !is_owned(id)) begin
			exp_rsp_cnt++;
		end
	endtask

	task automatic go_idle();
		@(posedge clk100);
		#DRIVE_DLY;
		cmd = '0;
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	initial begin
		reset_i = 1'b1;
		cmd = '0;
		rnd = $urandom(SEED);
		repeat (RESET_CYCLES) @(posedge clk100);
		#DRIVE_DLY;
		reset_i = 1'b0;

		// every register straight out of reset
		for (int n = 1; n <= NUM_NODES; n++) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				send_cmd(1'b0, node_id_t'(n), reg_idx_t'(i), '0);
			end
		end

		// four writes then the four reads back, per node
		for (int n = 1; n <= NUM_NODES; n++) begin
			for (int i = 0; i < 4; i++) begin
				send_cmd(1'b1, node_id_t'(n), reg_idx_t'(i * 5),
					fill_word(node_id_t'(n), reg_idx_t'(i * 5)));
			end
			for (int i = 0; i < 4; i++) begin
				send_cmd(1'b0, node_id_t'(n), reg_idx_t'(i * 5), '0);
			end
		end

		// mixed burst, several in flight at once
		send_cmd(1'b0, 3'd1, 4'd0, '0);
		send_cmd(1'b0, 3'd6, 4'd3, '0);
		send_cmd(1'b1, 3'd2, 4'd7, 32'hdead_beef);
		send_cmd(1'b0, 3'd2, 4'd7, '0);
		send_cmd(1'b0, 3'd4, 4'd15, '0);
		send_cmd(1'b1, 3'd0, 4'd1, 32'h1234_5678);
		send_cmd(1'b0, 3'd3, 4'd10, '0);
		send_cmd(1'b0, 3'd7, 4'd9, '0);

		// read right behind a write to the same register
		for (int n = 1; n <= NUM_NODES; n++) begin
			send_cmd(1'b1, node_id_t'(n), 4'd8, ~fill_word(node_id_t'(n), 4'd8));
			send_cmd(1'b0, node_id_t'(n), 4'd8, '0);
		end

		// ids 0 and 5..7, write then read each
		for (int n = 0; n < (1 << NODE_ID_W); n++) begin
			if (!is_owned(node_id_t'(n))) begin
				send_cmd(1'b1, node_id_t'(n), reg_idx_t'(n), fill_word(node_id_t'(n), 4'd0));
				send_cmd(1'b0, node_id_t'(n), reg_idx_t'(n), '0);
			end
		end

		// random mix, roughly one idle slot in eight
		for (int i = 0; i < RAND_CMDS; i++) begin
			rnd = $urandom;
			if (rnd[2:0] == 3'd0) begin
				go_idle();
			end else begin
				// half the time force an owned node
				if (rnd[7]) begin
					rnd_id = node_id_t'(rnd[5:4]) + 3'd1;
				end else begin
					rnd_id = rnd[6:4];
				end
				send_cmd(rnd[3], rnd_id, rnd[11:8], $urandom);
			end
		end
		go_idle();

		// drain, the timeout guards a lost response
		while (got_rsp_cnt < exp_rsp_cnt) begin
			@(posedge clk100);
			#DRIVE_DLY;
		end
		// a stray response would show up within one latency
		repeat (RING_LATENCY + 1) @(posedge clk100);
		#DRIVE_DLY;
		if (got_rsp_cnt != exp_rsp_cnt) begin
			$display("FAIL %0t: expected %0d responses, got %0d", $time,
				exp_rsp_cnt, got_rsp_cnt);
			drain_errs++;
		end

		assert_errs = u_dut.u_checker.fail_cnt;
		$display("errors: %0d from assertions, %0d from drain check, %0d responses",
			assert_errs, drain_errs, got_rsp_cnt);
		if (assert_errs == 0 && drain_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* dv/ring_soc_checker.sv */
module ring_soc_checker (
	input logic                clk100,
	input logic                reset_i,
	// host side as seen by the top level
	input ring_pkg::host_cmd_t cmd_i,
	input ring_pkg::host_rsp_t rsp_i,
	// every ring slot, for the reset check
	input ring_pkg::packet_t   ring_pkt_i [ring_pkg::NUM_NODES+1]
);
	import ring_pkg::*;

	localparam node_id_t LAST_ID = node_id_t'(NUM_NODES);

	// ------------------------------
	// shadow register model
	// ------------------------------

	// indexed by full node id, ids 0 and 5..7 never written
	word_t shadow [1 << NODE_ID_W][NUM_REGS];
	node_id_t cmd_id;
	reg_idx_t cmd_idx;
	logic cmd_owned;
	host_rsp_t exp_now;

	// host address is {node id, register index}
	assign cmd_id = cmd_i.adr[HOST_ADR_W-1 -: NODE_ID_W];
	assign cmd_idx = cmd_i.adr[REG_IDX_W-1:0];
	// nodes 1..4 own an id, the rest bounce
	assign cmd_owned = (cmd_id != NIC_ID) && (cmd_id <= LAST_ID);

	// commands travel in lockstep, so command order is access order
	always_ff @(posedge clk100) begin
		if (reset_i) begin
			for (int n = 0; n < (1 << NODE_ID_W); n++) begin
				for (int i = 0; i < NUM_REGS; i++) begin
					shadow[n][i] <= '0;
				end
			end
		end else if (cmd_i.valid && cmd_i.we && cmd_owned) begin
			shadow[cmd_id][cmd_idx] <= cmd_i.dat;
		end
	end

	// what the host should see for this cycle's command
	always_comb begin
		exp_now = '0;
		if (cmd_i.valid && !cmd_owned) begin
			// bounce, read or write alike
			exp_now.valid = 1'b1;
			exp_now.err = 1'b1;
		end else if (cmd_i.valid && !cmd_i.we) begin
			// old value, before this command's own effect
			exp_now.valid = 1'b1;
			exp_now.dat = shadow[cmd_id][cmd_idx];
		end
	end

	// ------------------------------
	// response history
	// ------------------------------

	// hist[k] holds the command sampled k edges before the latest one
	// so hist[RING_LATENCY] lines up with the registered response
	host_rsp_t hist [0:RING_LATENCY];

	always_ff @(posedge clk100) begin
		if (reset_i) begin
			for (int k = 0; k <= RING_LATENCY; k++) begin
				hist[k] <= '0;
			end
		end else begin
			hist[0] <= exp_now;
			for (int k = 1; k <= RING_LATENCY; k++) begin
				hist[k] <= hist[k-1];
			end
		end
	end

	// high in the cycle after a reset edge
	logic reset_q = 1'b0;
	logic [NUM_NODES:0] slot_valid;

	always @(posedge clk100) begin
		reset_q <= reset_i;
	end

	always_comb begin
		for (int k = 0; k <= NUM_NODES; k++) begin
			slot_valid[k] = ring_pkt_i[k].valid;
		end
	end

	// ------------------------------
	// assertions
	// ------------------------------

	// one count per assertion, summed for the testbench
	int unsigned n_valid;
	int unsigned n_err;
	int unsigned n_dat;
	int unsigned n_rst_rsp;
	int unsigned n_rst_ring;
	int unsigned fail_cnt;

	assign fail_cnt = n_valid + n_err + n_dat + n_rst_rsp + n_rst_ring;

	// response strobe exactly RING_LATENCY after each read or bounce
	a_rsp_valid: assert property (@(posedge clk100) disable iff (reset_i)
		rsp_i.valid == hist[RING_LATENCY].valid)
	else begin
		n_valid++;
		$error("FAIL %0t: response strobe %0b, expected %0b", $time,
			$sampled(rsp_i.valid), $sampled(hist[RING_LATENCY].valid));
	end

	a_rsp_err: assert property (@(posedge clk100) disable iff (reset_i)
		!hist[RING_LATENCY].valid || (rsp_i.err == hist[RING_LATENCY].err))
	else begin
		n_err++;
		$error("FAIL %0t: response err %0b, expected %0b", $time,
			$sampled(rsp_i.err), $sampled(hist[RING_LATENCY].err));
	end

	// read data against the shadow, zero on bounces
	a_rsp_dat: assert property (@(posedge clk100) disable iff (reset_i)
		!hist[RING_LATENCY].valid || (rsp_i.dat == hist[RING_LATENCY].dat))
	else begin
		n_dat++;
		$error("FAIL %0t: response data %h, expected %h", $time,
			$sampled(rsp_i.dat), $sampled(hist[RING_LATENCY].dat));
	end

	a_reset_rsp: assert property (@(posedge clk100) reset_q |-> !rsp_i.valid)
	else begin
		n_rst_rsp++;
		$error("FAIL %0t: response strobe high after a reset edge", $time);
	end

	// no slot may survive reset
	a_reset_ring: assert property (@(posedge clk100) reset_q |-> (slot_valid == '0))
	else begin
		n_rst_ring++;
		$error("FAIL %0t: ring slots %b still valid after a reset edge", $time,
			$sampled(slot_valid));
	end

endmodule

bind ring_soc ring_soc_checker u_checker (
	.clk100    (clk100),
	.reset_i   (reset_i),
	.cmd_i     (cmd_i),
	.rsp_i     (rsp_o),
	.ring_pkt_i(ring_pkt)
);

/* rtl/ring_soc.sv */
module ring_soc (
	input  logic                clk100,
	input  logic                reset_i,
	// host command strobe
	input  ring_pkg::host_cmd_t cmd_i,
	// host response strobe, RING_LATENCY after the command
	output ring_pkg::host_rsp_t rsp_o
);
	import ring_pkg::*;

	// ------------------------------
	// ring wiring
	// ------------------------------

	// ring_pkt[0] leaves the nic
	// ring_pkt[k] leaves node k
	// ring_pkt[NUM_NODES] goes back into the nic
	packet_t ring_pkt [NUM_NODES+1];

	ring_nic u_nic (
		.clk100 (clk100),
		.reset_i(reset_i),
		.cmd_i  (cmd_i),
		.rsp_o  (rsp_o),
		.ring_i (ring_pkt[NUM_NODES]),
		.ring_o (ring_pkt[0])
	);

	// ------------------------------
	// node stages
	// ------------------------------

	// node k acts on a command k cycles after the nic samples it
	for (genvar g = 1; g <= NUM_NODES; g++) begin : gen_node
		ring_node #(
			.NODE_ID(node_id_t'(g))
		) u_node (
			.clk100 (clk100),
			.reset_i(reset_i),
			.pkt_i  (ring_pkt[g-1]),
			.pkt_o  (ring_pkt[g])
		);
	end

endmodule

/* rtl/ring_node.sv */
module ring_node #(
	// ring address owned by this stage
	parameter ring_pkg::node_id_t NODE_ID = 3'd1
) (
	input  logic              clk100,
	input  logic              reset_i,
	// slot from the previous stage
	input  ring_pkg::packet_t pkt_i,
	// slot to the next stage
	output ring_pkg::packet_t pkt_o
);
	import ring_pkg::*;

	// ------------------------------
	// local register file
	// ------------------------------

	word_t regs [NUM_REGS];
	word_t rd_dat;

	logic hit;
	logic is_wr;
	logic is_rd;

	// packet addressed to us
	assign hit = pkt_i.valid && (pkt_i.dst == NODE_ID);
	assign is_wr = hit && (pkt_i.op == OP_WRITE);
	// a stray response to our id just passes on
	assign is_rd = hit && (pkt_i.op == OP_READ);

	// old contents, before this cycle's write lands
	assign rd_dat = regs[pkt_i.idx];

	always_ff @(posedge clk100) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (is_wr) begin
			regs[pkt_i.idx] <= pkt_i.dat;
		end
	end

	// ------------------------------
	// slot rewrite
	// ------------------------------

	packet_t pkt_nxt;

	always_comb begin
		// default is pass through untouched, err included
		pkt_nxt = pkt_i;
		if (is_wr) begin
			// write consumed, slot freed
			pkt_nxt.valid = 1'b0;
		end else if (is_rd) begin
			// turn the read round toward its sender
			pkt_nxt.op = OP_RESP;
			pkt_nxt.dst = pkt_i.src;
			pkt_nxt.src = NODE_ID;
			pkt_nxt.dat = rd_dat;
		end
	end

	// one registered hop, exactly one cycle
	always_ff @(posedge clk100) begin
		pkt_o <= pkt_nxt;
		if (reset_i) begin
			pkt_o.valid <= 1'b0;
		end
	end

endmodule

/* rtl/ring_nic.sv */
module ring_nic (
	input  logic                clk100,
	input  logic                reset_i,
	// host command strobe, one per cycle at most
	input  ring_pkg::host_cmd_t cmd_i,
	output ring_pkg::host_rsp_t rsp_o,
	// ring return from the last node
	input  ring_pkg::packet_t   ring_i,
	// ring feed into the first node
	output ring_pkg::packet_t   ring_o
);
	import ring_pkg::*;

	// ------------------------------
	// command side
	// ------------------------------

	node_id_t cmd_dst;
	reg_idx_t cmd_idx;
	packet_t req_pkt;

	// upper bits pick the node
	assign cmd_dst = cmd_i.adr[HOST_ADR_W-1 -: NODE_ID_W];
	// lower bits pick the register inside it
	assign cmd_idx = cmd_i.adr[REG_IDX_W-1:0];

	always_comb begin
		req_pkt.valid = cmd_i.valid;
		req_pkt.op = cmd_i.we ? OP_WRITE : OP_READ;
		req_pkt.dst = cmd_dst;
		// replies find their way home by src
		req_pkt.src = NIC_ID;
		req_pkt.idx = cmd_idx;
		// write data, ignored by reads
		req_pkt.dat = cmd_i.dat;
		// only ever set on the host side
		req_pkt.err = 1'b0;
	end

	// slot in front of the nic is always empty here
	// since every packet coming round is consumed below
	always_ff @(posedge clk100) begin
		ring_o <= req_pkt;
		if (reset_i) begin
			ring_o.valid <= 1'b0;
		end
	end

	// ------------------------------
	// return side
	// ------------------------------

	logic ret_rsp;
	logic ret_bounce;
	host_rsp_t rsp_nxt;

	// read data from an owning node
	assign ret_rsp = ring_i.valid && (ring_i.op == OP_RESP) && (ring_i.dst == NIC_ID);

	// a request still unserved after a full turn
	// nobody owns its dst, which also covers dst == NIC_ID
	assign ret_bounce = ring_i.valid && (ring_i.op != OP_RESP);

	always_comb begin
		rsp_nxt.valid = ret_rsp || ret_bounce;
		rsp_nxt.err = ret_bounce;
		// bounced reads and writes both return zero
		if (ret_rsp) begin
			rsp_nxt.dat = ring_i.dat;
		end else begin
			rsp_nxt.dat = '0;
		end
	end

	// one cycle from ring_i to the host
	always_ff @(posedge clk100) begin
		rsp_o <= rsp_nxt;
		if (reset_i) begin
			rsp_o.valid <= 1'b0;
		end
	end

endmodule

/* rtl/ring_pkg.sv */
package ring_pkg;

	// ------------------------------
	// field widths
	// ------------------------------

	localparam int WORD_W = 32;
	localparam int NODE_ID_W = 3;
	localparam int REG_IDX_W = 4;
	// host address is {node id, register index}
	localparam int HOST_ADR_W = NODE_ID_W + REG_IDX_W;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [NODE_ID_W-1:0] node_id_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [HOST_ADR_W-1:0] host_adr_t;
	typedef logic [1:0] pkt_op_t;

	// ------------------------------
	// packet opcodes
	// ------------------------------

	localparam pkt_op_t OP_WRITE = 2'd0;
	localparam pkt_op_t OP_READ = 2'd1;
	// read data on its way back to the nic
	localparam pkt_op_t OP_RESP = 2'd2;

	// ------------------------------
	// ring layout
	// ------------------------------

	// nic sits at ring address 0
	localparam node_id_t NIC_ID = 3'd0;
	localparam int NUM_NODES = 4;
	localparam int NUM_REGS = 1 << REG_IDX_W;
	// nic + four nodes + response register
	localparam int RING_LATENCY = 5;

	// one ring slot, registered at every hop
	typedef struct packed {
		logic valid;
		pkt_op_t op;
		node_id_t dst;
		node_id_t src;
		reg_idx_t idx;
		word_t dat;
		logic err;
	} packet_t;

	// host side, plain strobes
	typedef struct packed {
		logic valid;
		logic we;
		host_adr_t adr;
		word_t dat;
	} host_cmd_t;

	typedef struct packed {
		logic valid;
		logic err;
		word_t dat;
	} host_rsp_t;

endpackage
